// File: common/matmul_defs.svh
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// Array dimension and lane count of every vector
`define MM_SIZE 4
// Element width in bits
`define MM_DWIDTH 8
// Operand and result memory address width
`define MM_AWIDTH 11
`define MM_STRIDE_WIDTH 8
// Run cycle counter width
`define MM_CNT_WIDTH 8

// Operand memory read latency in cycles
`define MM_MEM_LATENCY 1
// Operand flop, product flop, accumulator
`define MM_MAC_CYCLES 3

// Cycle on which column 0 of C is final in the grid (13 for a 4x4)
`define MM_LATCH_CYCLE ((`MM_SIZE << 2) - `MM_SIZE - 2 + `MM_MAC_CYCLES)
// Count that registers the done pulse (16 for a 4x4)
`define MM_DONE_CYCLE ((`MM_SIZE << 2) - 3 + `MM_MAC_CYCLES)

`endif

// File: common/matmul_data_pkg.sv
`default_nettype none

`include "matmul_defs.svh"

package matmul_data_pkg;

  //////////////////////////////
  // Element level
  //////////////////////////////

  // One matrix element in two's complement
  typedef logic signed [`MM_DWIDTH-1:0] elem_t;

  // Full precision product before saturation
  typedef logic signed [2*`MM_DWIDTH-1:0] product_t;

  //////////////////////////////
  // Vector and matrix level
  //////////////////////////////

  // One memory word, lane 0 in the low bits
  // A column of A or a row of B
  typedef elem_t [`MM_SIZE-1:0] vec_t;

  // Grid outputs
  // Outer index is the column, inner index the row
  typedef vec_t [`MM_SIZE-1:0] mat_t;

endpackage

`default_nettype wire

// File: common/matmul_ctrl_pkg.sv
`default_nettype none

`include "matmul_defs.svh"

package matmul_ctrl_pkg;

  // Word address into the operand and result memories
  typedef logic [`MM_AWIDTH-1:0] addr_t;
  typedef logic [`MM_STRIDE_WIDTH-1:0] stride_t;
  // Bit n set means lane or step n is valid
  typedef logic [`MM_SIZE-1:0] mask_t;
  // Cycles since the run started
  typedef logic [`MM_CNT_WIDTH-1:0] cyc_t;

  //////////////////////////////
  // Host configuration
  //////////////////////////////

  typedef struct packed {
    addr_t   a_base;
    addr_t   b_base;
    addr_t   c_base;
    stride_t a_stride;
    stride_t b_stride;
    stride_t c_stride;
  } mm_cfg_t;

  // a_rows gates A lanes, b_cols gates B lanes, k_steps gates whole vectors
  typedef struct packed {
    mask_t a_rows;
    mask_t k_steps;
    mask_t b_cols;
  } mm_mask_t;

  // Result write strobe, one column of C per beat
  typedef struct packed {
    logic                  valid;
    addr_t                 addr;
    matmul_data_pkg::vec_t data;
  } c_wr_t;

  typedef enum logic [1:0] {DRAIN_IDLE, DRAIN_EMIT, DRAIN_HOLD} drain_state_e;

endpackage

`default_nettype wire

// File: pe_array/processing_element.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module processing_element (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  matmul_data_pkg::elem_t i_a,
  input  matmul_data_pkg::elem_t i_b,
  output matmul_data_pkg::elem_t o_a,
  output matmul_data_pkg::elem_t o_b,
  output matmul_data_pkg::elem_t o_c
);

  // Signed element range
  localparam int ELEM_MAX = (1 << (`MM_DWIDTH - 1)) - 1;
  localparam int ELEM_MIN = -(1 << (`MM_DWIDTH - 1));

  matmul_data_pkg::elem_t   a_q;
  matmul_data_pkg::elem_t   b_q;
  matmul_data_pkg::product_t prod_q;
  matmul_data_pkg::elem_t   prod_sat;
  matmul_data_pkg::elem_t   acc;

  // Operand flops double as the forward path to the neighbours
  // Stage 2 holds the full product, accumulator wraps modulo 256
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      acc    <= '0;
    end else begin
      a_q    <= i_a;
      b_q    <= i_b;
      prod_q <= a_q * b_q;
      acc    <= acc + prod_sat;
    end
  end

  // Clamp product into element range
  always_comb begin
    if (prod_q > ELEM_MAX) begin
      prod_sat = matmul_data_pkg::elem_t'(ELEM_MAX);
    end else if (prod_q < ELEM_MIN) begin
      prod_sat = matmul_data_pkg::elem_t'(ELEM_MIN);
    end else begin
      prod_sat = matmul_data_pkg::elem_t'(prod_q);
    end
  end

  assign o_a = a_q;
  assign o_b = b_q;
  assign o_c = acc;

endmodule

`default_nettype wire

// File: pe_array/pe_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module pe_array (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_start,
  input  matmul_data_pkg::vec_t i_a,
  input  matmul_data_pkg::vec_t i_b,
  output matmul_data_pkg::mat_t o_c
);

  // a_link[r][c] enters PE (r, c) from the left
  // Column MM_SIZE is what leaves the right edge
  matmul_data_pkg::elem_t a_link [`MM_SIZE][`MM_SIZE+1];
  // b_link[r][c] enters PE (r, c) from above
  matmul_data_pkg::elem_t b_link [`MM_SIZE+1][`MM_SIZE];

  //////////////////////////////
  // Grid edges
  //////////////////////////////

  // Lane i of A feeds row i, lane j of B feeds column j
  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_edge
    assign a_link[i][0] = i_a[i];
    assign b_link[0][i] = i_b[i];
  end

  //////////////////////////////
  // PE grid
  //////////////////////////////

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_row
    for (genvar c = 0; c < `MM_SIZE; c++) begin : g_col
      // A moves right, B moves down, C stays in place
      processing_element pe_row_col (
        .clk     (clk),
        .reset   (reset),
        .i_start (i_start),
        .i_a     (a_link[r][c]),
        .i_b     (b_link[r][c]),
        .o_a     (a_link[r][c+1]),
        .o_b     (b_link[r+1][c]),
        .o_c     (o_c[c][r])
      );
    end
  end

endmodule

`default_nettype wire

// File: src/matmul_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module matmul_sequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_start,
  output matmul_ctrl_pkg::cyc_t o_cycle,
  output logic                  o_latch,
  output logic                  o_done
);

  //////////////////////////////
  // Run cycle counter
  //////////////////////////////

  // Count equals the cycle number of the run
  // Cycle 0 is the first edge that sees i_start high
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_cycle <= '0;
      o_done  <= 1'b0;
    end else begin
      // Stop at all ones so a long held start never wraps back into a latch
      if (o_cycle != '1) begin
        o_cycle <= o_cycle + 1'b1;
      end
      // One cycle pulse, the count only passes this value once
      o_done <= (o_cycle == matmul_ctrl_pkg::cyc_t'(`MM_DONE_CYCLE));
    end
  end

  //////////////////////////////
  // Result capture strobe
  //////////////////////////////

  // Column 0 of C is final in the grid on this cycle
  assign o_latch = (o_cycle == matmul_ctrl_pkg::cyc_t'(`MM_LATCH_CYCLE));

  // Host sees exactly one done per run
  done_single_pulse: assert property (
    @(posedge clk) disable iff (reset)
    o_done |=> !o_done
  );

endmodule

`default_nettype wire

// File: src/operand_feeder.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module operand_feeder (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_start,
  input  matmul_ctrl_pkg::cyc_t    i_cycle,
  input  matmul_ctrl_pkg::addr_t   i_base,
  input  matmul_ctrl_pkg::stride_t i_stride,
  input  matmul_data_pkg::vec_t    i_rd_data,
  input  matmul_ctrl_pkg::mask_t   i_lane_mask,
  input  matmul_ctrl_pkg::mask_t   i_k_mask,
  output matmul_ctrl_pkg::addr_t   o_rd_addr,
  output matmul_data_pkg::vec_t    o_skewed
);

  localparam int STEP_W = $clog2(`MM_SIZE);

  logic                       access;
  // Read issued, delayed by the memory latency
  logic [`MM_MEM_LATENCY-1:0] access_pipe;
  logic                       rd_valid;
  // Reduction step of the vector now on i_rd_data
  logic [STEP_W-1:0]          step;
  logic                       vec_ok;
  matmul_data_pkg::vec_t      qual;

  //////////////////////////////
  // Address generation
  //////////////////////////////

  // Rests one stride below base so the first step lands on base
  always_ff @(posedge clk) begin
    if (reset || !i_start || i_cycle >= matmul_ctrl_pkg::cyc_t'(`MM_SIZE)) begin
      o_rd_addr <= i_base - matmul_ctrl_pkg::addr_t'(i_stride);
      access    <= 1'b0;
    end else begin
      o_rd_addr <= o_rd_addr + matmul_ctrl_pkg::addr_t'(i_stride);
      access    <= 1'b1;
    end
  end

  //////////////////////////////
  // Return qualification
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      access_pipe <= '0;
      step        <= '0;
    end else begin
      access_pipe[0] <= access;
      for (int i = 1; i < `MM_MEM_LATENCY; i++) begin
        access_pipe[i] <= access_pipe[i-1];
      end
      // Counts returned vectors, wraps after the last step
      if (rd_valid) begin
        step <= step + 1'b1;
      end
    end
  end

  assign rd_valid = access_pipe[`MM_MEM_LATENCY-1];
  assign vec_ok   = rd_valid && i_k_mask[step];

  // Whole vector gated by window and step mask, single lanes by lane mask
  always_comb begin
    for (int n = 0; n < `MM_SIZE; n++) begin
      qual[n] = (vec_ok && i_lane_mask[n]) ? i_rd_data[n] : '0;
    end
  end

  //////////////////////////////
  // Lane skew
  //////////////////////////////

  // Lane n passes through n flops, a triangle of delay
  for (genvar n = 0; n < `MM_SIZE; n++) begin : g_lane
    if (n == 0) begin : g_direct
      assign o_skewed[n] = qual[n];
    end else begin : g_delay
      matmul_data_pkg::elem_t taps [n];

      always_ff @(posedge clk) begin
        if (reset || !i_start) begin
          for (int t = 0; t < n; t++) begin
            taps[t] <= '0;
          end
        end else begin
          taps[0] <= qual[n];
          for (int t = 1; t < n; t++) begin
            taps[t] <= taps[t-1];
          end
        end
      end

      assign o_skewed[n] = taps[n-1];
    end
  end

  // Address moves only on cycles 0 to MM_SIZE of a run
  // and never while a run holds the config stable
  addr_in_window: assert property (
    @(posedge clk) disable iff (reset)
    (i_start && $past(i_start) && $changed(o_rd_addr)) |->
      ($past(i_cycle) <= matmul_ctrl_pkg::cyc_t'(`MM_SIZE))
  );

endmodule

`default_nettype wire

// File: src/result_drain.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module result_drain (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_start,
  input  logic                     i_latch,
  input  logic                     i_done,
  input  matmul_ctrl_pkg::addr_t   i_c_base,
  input  matmul_ctrl_pkg::stride_t i_c_stride,
  input  matmul_data_pkg::mat_t    i_c,
  output matmul_ctrl_pkg::c_wr_t   o_c_wr
);

  localparam int BEAT_W = $clog2(`MM_SIZE);

  matmul_ctrl_pkg::drain_state_e state;
  // Column index of the next beat
  logic [BEAT_W-1:0]             beat;

  //////////////////////////////
  // Column write-out FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      state  <= matmul_ctrl_pkg::DRAIN_IDLE;
      beat   <= '0;
      o_c_wr <= '0;
    end else begin
      case (state)
        matmul_ctrl_pkg::DRAIN_IDLE: begin
          // Column 0 goes out at c_base
          if (i_latch) begin
            o_c_wr.valid <= 1'b1;
            o_c_wr.addr  <= i_c_base;
            o_c_wr.data  <= i_c[0];
            beat         <= 1'b1;
            state        <= matmul_ctrl_pkg::DRAIN_EMIT;
          end
        end
        matmul_ctrl_pkg::DRAIN_EMIT: begin
          // Later columns settle one cycle apart, same as the beats
          o_c_wr.valid <= 1'b1;
          o_c_wr.addr  <= o_c_wr.addr + matmul_ctrl_pkg::addr_t'(i_c_stride);
          o_c_wr.data  <= i_c[beat];
          beat         <= beat + 1'b1;
          if (beat == BEAT_W'(`MM_SIZE - 1)) begin
            state <= matmul_ctrl_pkg::DRAIN_HOLD;
          end
        end
        matmul_ctrl_pkg::DRAIN_HOLD: begin
          // Bus idles at zero until the run is closed
          o_c_wr <= '0;
          if (i_done) begin
            state <= matmul_ctrl_pkg::DRAIN_IDLE;
          end
        end
        default: state <= matmul_ctrl_pkg::DRAIN_IDLE;
      endcase
    end
  end

  // Sequencer done lands on the last beat, then the bus goes quiet
  done_on_last_beat: assert property (
    @(posedge clk) disable iff (reset)
    i_done |-> o_c_wr.valid ##1 !o_c_wr.valid
  );

endmodule

`default_nettype wire

// File: src/matmul_4x4.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_4x4 (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      i_start,
  input  matmul_ctrl_pkg::mm_cfg_t  i_cfg,
  input  matmul_ctrl_pkg::mm_mask_t i_mask,
  input  matmul_data_pkg::vec_t     i_a_data,
  input  matmul_data_pkg::vec_t     i_b_data,
  output matmul_ctrl_pkg::addr_t    o_a_addr,
  output matmul_ctrl_pkg::addr_t    o_b_addr,
  output matmul_ctrl_pkg::c_wr_t    o_c_wr,
  output logic                      o_done
);

  matmul_ctrl_pkg::cyc_t cycle;
  logic                  latch;
  // Skewed operand lanes into the left and top edges of the grid
  matmul_data_pkg::vec_t a_skewed;
  matmul_data_pkg::vec_t b_skewed;
  matmul_data_pkg::mat_t c_mat;

  matmul_sequencer seq_i (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .o_cycle (cycle),
    .o_latch (latch),
    .o_done  (o_done)
  );

  // A side: columns of A, lanes gated by row mask
  operand_feeder feed_a_i (
    .clk         (clk),
    .reset       (reset),
    .i_start     (i_start),
    .i_cycle     (cycle),
    .i_base      (i_cfg.a_base),
    .i_stride    (i_cfg.a_stride),
    .i_rd_data   (i_a_data),
    .i_lane_mask (i_mask.a_rows),
    .i_k_mask    (i_mask.k_steps),
    .o_rd_addr   (o_a_addr),
    .o_skewed    (a_skewed)
  );

  // B side: rows of B, lanes gated by column mask
  operand_feeder feed_b_i (
    .clk         (clk),
    .reset       (reset),
    .i_start     (i_start),
    .i_cycle     (cycle),
    .i_base      (i_cfg.b_base),
    .i_stride    (i_cfg.b_stride),
    .i_rd_data   (i_b_data),
    .i_lane_mask (i_mask.b_cols),
    .i_k_mask    (i_mask.k_steps),
    .o_rd_addr   (o_b_addr),
    .o_skewed    (b_skewed)
  );

  pe_array array_i (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .i_a     (a_skewed),
    .i_b     (b_skewed),
    .o_c     (c_mat)
  );

  result_drain drain_i (
    .clk        (clk),
    .reset      (reset),
    .i_start    (i_start),
    .i_latch    (latch),
    .i_done     (o_done),
    .i_c_base   (i_cfg.c_base),
    .i_c_stride (i_cfg.c_stride),
    .i_c        (c_mat),
    .o_c_wr     (o_c_wr)
  );

endmodule

`default_nettype wire

// File: tests/tb_matmul_checks.svh
`ifndef TB_MATMUL_CHECKS_SVH
`define TB_MATMUL_CHECKS_SVH

//////////////////////////////
// Failure reporting
//////////////////////////////

// First error ends the simulation
task automatic abort_run();
  $display("Test failures found");
  $fatal(1, "simulation stopped at first error");
endtask

// Timeouts and other non-value failures
task automatic fail_with(input string msg);
  $display("%s", msg);
  abort_run();
endtask

//////////////////////////////
// Value compares
//////////////////////////////

task automatic check_vec(input string name, input matmul_data_pkg::vec_t got,
                         input matmul_data_pkg::vec_t exp);
  if (got !== exp) begin
    $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
    abort_run();
  end
endtask

task automatic check_addr(input string name, input matmul_ctrl_pkg::addr_t got,
                          input matmul_ctrl_pkg::addr_t exp);
  if (got !== exp) begin
    $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
    abort_run();
  end
endtask

// Single bit strobes such as valid and done
task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
    abort_run();
  end
endtask

`endif

// File: tests/tb_matmul.sv
`timescale 1ns/10ps
`default_nettype none

`include "matmul_defs.svh"

module tb_matmul;

  localparam int MEM_WORDS = 1 << `MM_AWIDTH;
  // Host timing of one run, counted from the first edge with start high
  localparam int FIRST_BEAT_CYC = 14;
  localparam int DONE_CYC = 17;
  localparam int DONE_TIMEOUT = 40;

  logic                      clk;
  logic                      reset;
  logic                      start;
  matmul_ctrl_pkg::mm_cfg_t  cfg;
  matmul_ctrl_pkg::mm_mask_t mask;
  matmul_data_pkg::vec_t     a_data;
  matmul_data_pkg::vec_t     b_data;
  matmul_ctrl_pkg::addr_t    a_addr;
  matmul_ctrl_pkg::addr_t    b_addr;
  matmul_ctrl_pkg::c_wr_t    c_wr;
  logic                      done;

  // Operand memory models
  matmul_data_pkg::vec_t  mem_a [MEM_WORDS];
  matmul_data_pkg::vec_t  mem_b [MEM_WORDS];
  matmul_ctrl_pkg::addr_t a_rd_q;
  matmul_ctrl_pkg::addr_t b_rd_q;

  // Expected result of the run in flight, column then row
  matmul_data_pkg::mat_t exp_c;
  int                    seed;
  int                    run_cyc;

  `include "tb_matmul_checks.svh"

  matmul_4x4 dut_i (
    .clk      (clk),
    .reset    (reset),
    .i_start  (start),
    .i_cfg    (cfg),
    .i_mask   (mask),
    .i_a_data (a_data),
    .i_b_data (b_data),
    .o_a_addr (a_addr),
    .o_b_addr (b_addr),
    .o_c_wr   (c_wr),
    .o_done   (done)
  );

  always #50 clk = ~clk;

  // Address seen on one edge, data back before the next
  always @(posedge clk) begin
    a_rd_q <= a_addr;
    b_rd_q <= b_addr;
  end

  always @(negedge clk) begin
    a_data <= mem_a[a_rd_q];
    b_data <= mem_b[b_rd_q];
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Strided address, wraps with the address width
  function automatic matmul_ctrl_pkg::addr_t step_addr(input matmul_ctrl_pkg::addr_t base,
                                                       input matmul_ctrl_pkg::stride_t stride,
                                                       input int k);
    return matmul_ctrl_pkg::addr_t'(base + k * stride);
  endfunction

  // Cycles 1 to 4 walk the steps, otherwise one stride below base
  function automatic matmul_ctrl_pkg::addr_t rd_addr_at(input matmul_ctrl_pkg::addr_t base,
                                                        input matmul_ctrl_pkg::stride_t stride,
                                                        input int cyc);
    if (cyc >= 1 && cyc <= `MM_SIZE) begin
      return step_addr(base, stride, cyc - 1);
    end
    return step_addr(base, stride, -1);
  endfunction

  // C[i][j] is the wrapped sum of saturated products over allowed steps
  function automatic matmul_data_pkg::mat_t ref_matmul(input matmul_ctrl_pkg::mm_cfg_t cf,
                                                       input matmul_ctrl_pkg::mm_mask_t mk);
    matmul_data_pkg::mat_t c;
    matmul_data_pkg::vec_t av;
    matmul_data_pkg::vec_t bv;
    int                    p;
    int                    sum;
    for (int i = 0; i < `MM_SIZE; i++) begin
      for (int j = 0; j < `MM_SIZE; j++) begin
        sum = 0;
        for (int k = 0; k < `MM_SIZE; k++) begin
          // Column k of A and row k of B
          av = mem_a[step_addr(cf.a_base, cf.a_stride, k)];
          bv = mem_b[step_addr(cf.b_base, cf.b_stride, k)];
          if (mk.a_rows[i] && mk.b_cols[j] && mk.k_steps[k]) begin
            p = int'(av[i]) * int'(bv[j]);
            if (p > 127) begin
              p = 127;
            end else if (p < -128) begin
              p = -128;
            end
            sum += p;
          end
        end
        c[j][i] = matmul_data_pkg::elem_t'(sum);
      end
    end
    return c;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Mode 0 small values, mode 1 range edges, otherwise all 127
  function automatic matmul_data_pkg::elem_t pick_elem(input int mode);
    int r;
    r = $random(seed);
    if (mode == 0) begin
      return matmul_data_pkg::elem_t'(r % 8);
    end
    if (mode != 1) begin
      return 8'sh7f;
    end
    case (r & 3)
      0: return 8'sh7f;
      1: return 8'sh80;
      2: return 8'shff;
      default: return 8'sh64;
    endcase
  endfunction

  // Background words derive from the whole address
  task automatic fill_background();
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem_a[a] = 32'(a * 32'h9e3779b1);
      mem_b[a] = 32'((a ^ 32'h7ff) * 32'h85ebca6b);
    end
  endtask

  task automatic load_operands(input int mode);
    matmul_data_pkg::vec_t va;
    matmul_data_pkg::vec_t vb;
    for (int k = 0; k < `MM_SIZE; k++) begin
      for (int n = 0; n < `MM_SIZE; n++) begin
        va[n] = pick_elem(mode);
        vb[n] = pick_elem(mode);
      end
      mem_a[step_addr(cfg.a_base, cfg.a_stride, k)] = va;
      mem_b[step_addr(cfg.b_base, cfg.b_stride, k)] = vb;
    end
  endtask

  // Done is sampled on the edge, start drops on the falling edge after
  task automatic wait_for_done();
    for (int n = 0; n < DONE_TIMEOUT; n++) begin
      @(posedge clk);
      if (done) begin
        return;
      end
    end
    fail_with("Timeout: o_done did not pulse within 40 cycles of start");
  endtask

  // Config settles one cycle before start so the rest address is current
  task automatic run_case(input int mode, input bit rand_masks);
    @(negedge clk);
    cfg.a_base   = 11'($random(seed));
    cfg.b_base   = 11'($random(seed));
    cfg.c_base   = 11'($random(seed));
    cfg.a_stride = 8'($random(seed));
    cfg.b_stride = 8'($random(seed));
    cfg.c_stride = 8'($random(seed));
    mask = rand_masks ? 12'($random(seed)) : '1;
    load_operands(mode);
    exp_c = ref_matmul(cfg, mask);
    @(negedge clk);
    start = 1'b1;
    wait_for_done();
    @(negedge clk);
    start = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      run_cyc = 0;
    end else if (!start) begin
      // Idle bus between runs
      check_flag("o_c_wr.valid", c_wr.valid, 1'b0);
      check_flag("o_done", done, 1'b0);
      check_vec("o_c_wr.data", c_wr.data, '0);
      run_cyc = 0;
    end else begin
      check_addr("o_a_addr", a_addr, rd_addr_at(cfg.a_base, cfg.a_stride, run_cyc));
      check_addr("o_b_addr", b_addr, rd_addr_at(cfg.b_base, cfg.b_stride, run_cyc));
      check_flag("o_c_wr.valid", c_wr.valid,
                 run_cyc >= FIRST_BEAT_CYC && run_cyc <= DONE_CYC);
      check_flag("o_done", done, run_cyc == DONE_CYC);
      // Beat k carries column k
      if (c_wr.valid) begin
        check_addr("o_c_wr.addr", c_wr.addr,
                   step_addr(cfg.c_base, cfg.c_stride, run_cyc - FIRST_BEAT_CYC));
        check_vec("o_c_wr.data", c_wr.data, exp_c[run_cyc - FIRST_BEAT_CYC]);
      end
      run_cyc++;
    end
  end

  initial begin
    seed    = 32'hfc183273;
    clk     = 1'b0;
    reset   = 1'b1;
    start   = 1'b0;
    cfg     = '0;
    mask    = '0;
    a_data  = '0;
    b_data  = '0;
    a_rd_q  = '0;
    b_rd_q  = '0;
    exp_c   = '0;
    run_cyc = 0;
    fill_background();
    repeat (8) @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);
    // Full masks, then a second run with fresh data
    run_case(0, 1'b0);
    run_case(0, 1'b0);
    for (int r = 0; r < 4; r++) begin
      run_case(0, 1'b1);
    end
    // Saturation and wrap
    run_case(2, 1'b0);
    run_case(1, 1'b0);
    run_case(1, 1'b1);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: systolic_matmul.f
+incdir+common
+incdir+tests
common/matmul_data_pkg.sv
common/matmul_ctrl_pkg.sv
pe_array/processing_element.sv
pe_array/pe_array.sv
src/matmul_sequencer.sv
src/operand_feeder.sv
src/result_drain.sv
src/matmul_4x4.sv
tests/tb_matmul.sv
